/* Makefile */
VERILATOR ?= verilator
TOP       ?= stonyman_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

$(OBJ_DIR)/V$(TOP): $(FILELIST) design/*.sv verif/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@out=$$($(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
design/stonyman_pkg.sv
design/stonyman_settings.sv
design/stonyman_pin_driver.sv
design/stonyman_sequencer.sv
design/stonyman_top.sv
verif/stonyman_chk.sv
verif/stonyman_tb.sv

/* design/stonyman_pin_driver.sv */
`timescale 1ns/100ps

module stonyman_pin_driver
    import stonyman_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // Command from the sequencer
    input  logic       cmd_req,
    input  logic       cmd_is_value,
    input  logic       cmd_force_reset,
    input  reg_value_t cmd_target,
    output logic       cmd_ack,

    // Chip pulse lines
    output logic       resp,
    output logic       incp,
    output logic       resv,
    output logic       incv
);

    logic [DRV_STATE_WIDTH-1:0] drv_state;
    logic [PULSE_CNT_WIDTH-1:0] phase_cnt;
    logic                       pulse_reset;

    // Shadow of the chip state
    reg_index_t shadow_ptr;
    reg_value_t shadow_regs [NUM_REGS];

    reg_value_t cur_value;
    logic       at_target;
    logic       above_target;
    logic       pulse_on;

    ////////////////////////////////////////
    // Compare against the commanded target
    ////////////////////////////////////////
    always_comb begin
        if (cmd_is_value) begin
            cur_value = shadow_regs[shadow_ptr];
        end else begin
            cur_value = reg_value_t'(shadow_ptr);
        end
    end

    assign at_target    = (cur_value == cmd_target);
    assign above_target = (cur_value > cmd_target);

    ////////////////////////////////////////
    // Pin decode
    ////////////////////////////////////////
    assign pulse_on = (drv_state == DRV_HIGH);
    assign resp     = pulse_on && pulse_reset && !cmd_is_value;
    assign incp     = pulse_on && !pulse_reset && !cmd_is_value;
    assign resv     = pulse_on && pulse_reset && cmd_is_value;
    assign incv     = pulse_on && !pulse_reset && cmd_is_value;
    assign cmd_ack  = (drv_state == DRV_ACK);

    always_ff @(posedge clk) begin
        if (reset) begin
            drv_state   <= DRV_IDLE;
            phase_cnt   <= '0;
            pulse_reset <= 1'b0;
            shadow_ptr  <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                shadow_regs[i] <= '0;
            end
        end else begin
            case (drv_state)
                DRV_IDLE: begin
                    if (cmd_req) begin
                        if (cmd_force_reset) begin
                            // Forced commands always open with a reset pulse
                            pulse_reset <= 1'b1;
                            phase_cnt   <= PULSE_CNT_LOAD;
                            drv_state   <= DRV_HIGH;
                        end else if (at_target) begin
                            drv_state <= DRV_ACK;
                        end else begin
                            pulse_reset <= above_target;
                            phase_cnt   <= PULSE_CNT_LOAD;
                            drv_state   <= DRV_HIGH;
                        end
                    end
                end
                DRV_HIGH: begin
                    if (phase_cnt == '0) begin
                        drv_state <= DRV_LOW;
                        // Chip acts on the falling edge
                        if (cmd_is_value) begin
                            if (pulse_reset) begin
                                shadow_regs[shadow_ptr] <= '0;
                            end else begin
                                shadow_regs[shadow_ptr] <= shadow_regs[shadow_ptr] +
                                                           reg_value_t'(1);
                            end
                        end else begin
                            if (pulse_reset) begin
                                shadow_ptr <= '0;
                            end else begin
                                shadow_ptr <= shadow_ptr + reg_index_t'(1);
                            end
                        end
                    end else begin
                        phase_cnt <= phase_cnt - 1'b1;
                    end
                end
                DRV_LOW: begin
                    // One low cycle before the next pulse or the ack
                    if (at_target) begin
                        drv_state <= DRV_ACK;
                    end else begin
                        pulse_reset <= above_target;
                        phase_cnt   <= PULSE_CNT_LOAD;
                        drv_state   <= DRV_HIGH;
                    end
                end
                DRV_ACK: begin
                    if (!cmd_req) begin
                        drv_state <= DRV_IDLE;
                    end
                end
                default: begin
                    drv_state <= DRV_IDLE;
                end
            endcase
        end
    end

endmodule

/* design/stonyman_pkg.sv */
package stonyman_pkg;

    ////////////////////////////////////////
    // Chip word types
    ////////////////////////////////////////
    typedef logic [2:0] reg_index_t;
    typedef logic [7:0] reg_value_t;
    typedef logic [6:0] pixel_coord_t;

    // Register map by chip pointer value
    localparam reg_index_t COLSEL_IDX = 3'd0;
    localparam reg_index_t ROWSEL_IDX = 3'd1;
    localparam reg_index_t VSW_IDX    = 3'd2;
    localparam reg_index_t HSW_IDX    = 3'd3;
    localparam reg_index_t VREF_IDX   = 3'd4;
    localparam reg_index_t CONFIG_IDX = 3'd5;
    localparam reg_index_t NBIAS_IDX  = 3'd6;
    localparam reg_index_t AOBIAS_IDX = 3'd7;

    localparam int NUM_REGS       = 8;
    localparam int ROW_RESOLUTION = 112;
    localparam int COL_RESOLUTION = 112;
    localparam int SWITCH_WIDTH   = 8;
    localparam int BIAS_WIDTH     = 6;

    ////////////////////////////////////////
    // Pulse shape
    ////////////////////////////////////////
    localparam int PULSE_HIGH_CYCLES = 1;
    localparam int PULSE_CNT_WIDTH   = $clog2(PULSE_HIGH_CYCLES + 1);
    localparam logic [PULSE_CNT_WIDTH-1:0] PULSE_CNT_LOAD =
        PULSE_CNT_WIDTH'(PULSE_HIGH_CYCLES - 1);

    // Pin driver states
    localparam int DRV_STATE_WIDTH = 2;
    localparam logic [DRV_STATE_WIDTH-1:0] DRV_IDLE = 2'd0;
    localparam logic [DRV_STATE_WIDTH-1:0] DRV_HIGH = 2'd1;
    localparam logic [DRV_STATE_WIDTH-1:0] DRV_LOW  = 2'd2;
    localparam logic [DRV_STATE_WIDTH-1:0] DRV_ACK  = 2'd3;

    // Sequencer states
    localparam int SEQ_STATE_WIDTH = 4;
    localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_INIT_RESET = 4'd0;
    localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_INIT_PTR   = 4'd1;
    localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_INIT_VAL   = 4'd2;
    localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_IDLE       = 4'd3;
    localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_ROW_PTR    = 4'd4;
    localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_ROW_VAL    = 4'd5;
    localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_COL_PTR    = 4'd6;
    localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_COL_VAL    = 4'd7;
    localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_ADC_WAIT   = 4'd8;

endpackage

/* design/stonyman_sequencer.sv */
`timescale 1ns/100ps

module stonyman_sequencer
    import stonyman_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // Host and ADC
    input  logic         frame_capture_start,
    input  logic         capture_pixel,
    input  logic         adc_capture_done,
    output logic         frame_capture_done,
    output logic         adc_capture_start,
    output pixel_coord_t pixel_row,
    output pixel_coord_t pixel_col,

    // Settings lookup
    output reg_index_t   setting_sel,
    input  reg_value_t   setting_value,

    // Command to the pin driver
    output logic         cmd_req,
    output logic         cmd_is_value,
    output logic         cmd_force_reset,
    output reg_value_t   cmd_target,
    input  logic         cmd_ack
);

    logic [SEQ_STATE_WIDTH-1:0] state;
    logic [2:0]                 init_step;
    reg_index_t                 init_idx;
    logic                       cmd_state;
    logic                       cmd_done;
    logic                       last_col;
    logic                       last_row;
    logic                       pixel_advance;

    // Init walks the registers in chip bring-up order
    always_comb begin
        case (init_step)
            3'd0:    init_idx = COLSEL_IDX;
            3'd1:    init_idx = ROWSEL_IDX;
            3'd2:    init_idx = VSW_IDX;
            3'd3:    init_idx = HSW_IDX;
            3'd4:    init_idx = VREF_IDX;
            3'd5:    init_idx = NBIAS_IDX;
            3'd6:    init_idx = AOBIAS_IDX;
            default: init_idx = CONFIG_IDX;
        endcase
    end

    // Col and row select read back as zero
    assign setting_sel = init_idx;

    assign cmd_state = state inside {SEQ_INIT_RESET, SEQ_INIT_PTR, SEQ_INIT_VAL,
                                     SEQ_ROW_PTR, SEQ_ROW_VAL, SEQ_COL_PTR, SEQ_COL_VAL};
    assign cmd_done  = cmd_req && cmd_ack;
    assign last_col  = (pixel_col == pixel_coord_t'(COL_RESOLUTION - 1));
    assign last_row  = (pixel_row == pixel_coord_t'(ROW_RESOLUTION - 1));

    // Pixel finished by a mask skip or by a conversion
    assign pixel_advance = (state == SEQ_COL_VAL && cmd_done && !capture_pixel) ||
                           (state == SEQ_ADC_WAIT && adc_capture_done);

    ////////////////////////////////////////
    // Command fields held stable per state
    ////////////////////////////////////////
    always_comb begin
        cmd_is_value    = 1'b0;
        cmd_force_reset = 1'b0;
        cmd_target      = '0;
        case (state)
            SEQ_INIT_RESET: cmd_force_reset = 1'b1;
            SEQ_INIT_PTR:   cmd_target = reg_value_t'(init_idx);
            SEQ_INIT_VAL: begin
                cmd_is_value    = 1'b1;
                cmd_force_reset = 1'b1;
                cmd_target      = setting_value;
            end
            SEQ_ROW_PTR:    cmd_target = reg_value_t'(ROWSEL_IDX);
            SEQ_ROW_VAL: begin
                cmd_is_value = 1'b1;
                cmd_target   = reg_value_t'(pixel_row);
            end
            SEQ_COL_PTR:    cmd_target = reg_value_t'(COLSEL_IDX);
            SEQ_COL_VAL: begin
                cmd_is_value = 1'b1;
                cmd_target   = reg_value_t'(pixel_col);
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////
    // Main FSM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state              <= SEQ_INIT_RESET;
            init_step          <= '0;
            pixel_row          <= '0;
            pixel_col          <= '0;
            cmd_req            <= 1'b0;
            adc_capture_start  <= 1'b0;
            frame_capture_done <= 1'b0;
        end else begin
            adc_capture_start  <= 1'b0;
            frame_capture_done <= 1'b0;

            // New request only after the previous ack has dropped
            if (cmd_state && !cmd_req && !cmd_ack) begin
                cmd_req <= 1'b1;
            end else if (cmd_done) begin
                cmd_req <= 1'b0;
            end

            case (state)
                SEQ_INIT_RESET: if (cmd_done) state <= SEQ_INIT_PTR;
                SEQ_INIT_PTR:   if (cmd_done) state <= SEQ_INIT_VAL;
                SEQ_INIT_VAL: begin
                    if (cmd_done) begin
                        if (init_step == 3'(NUM_REGS - 1)) begin
                            state <= SEQ_IDLE;
                        end else begin
                            init_step <= init_step + 3'd1;
                            state     <= SEQ_INIT_PTR;
                        end
                    end
                end
                SEQ_IDLE: begin
                    if (frame_capture_start) begin
                        pixel_row <= '0;
                        pixel_col <= '0;
                        state     <= SEQ_ROW_PTR;
                    end
                end
                SEQ_ROW_PTR: if (cmd_done) state <= SEQ_ROW_VAL;
                SEQ_ROW_VAL: if (cmd_done) state <= SEQ_COL_PTR;
                SEQ_COL_PTR: if (cmd_done) state <= SEQ_COL_VAL;
                SEQ_COL_VAL: begin
                    if (cmd_done && capture_pixel) begin
                        adc_capture_start <= 1'b1;
                        state             <= SEQ_ADC_WAIT;
                    end
                end
                SEQ_ADC_WAIT: ;
                default: state <= SEQ_INIT_RESET;
            endcase

            // Raster stepping
            if (pixel_advance) begin
                if (!last_col) begin
                    pixel_col <= pixel_col + pixel_coord_t'(1);
                    state     <= SEQ_COL_VAL;
                end else if (!last_row) begin
                    pixel_col <= '0;
                    pixel_row <= pixel_row + pixel_coord_t'(1);
                    state     <= SEQ_ROW_PTR;
                end else begin
                    pixel_col          <= '0;
                    pixel_row          <= '0;
                    frame_capture_done <= 1'b1;
                    state              <= SEQ_IDLE;
                end
            end
        end
    end

endmodule

/* design/stonyman_settings.sv */
`timescale 1ns/100ps

module stonyman_settings
    import stonyman_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [SWITCH_WIDTH-1:0] vsw_value,
    input  logic [SWITCH_WIDTH-1:0] hsw_value,
    input  logic [BIAS_WIDTH-1:0]   vref_value,
    input  logic [BIAS_WIDTH-1:0]   config_value,
    input  logic [BIAS_WIDTH-1:0]   nbias_value,
    input  logic [BIAS_WIDTH-1:0]   aobias_value,
    input  reg_index_t              setting_sel,
    output reg_value_t              setting_value
);

    logic [SWITCH_WIDTH-1:0] vsw_q;
    logic [SWITCH_WIDTH-1:0] hsw_q;
    logic [BIAS_WIDTH-1:0]   vref_q;
    logic [BIAS_WIDTH-1:0]   config_q;
    logic [BIAS_WIDTH-1:0]   nbias_q;
    logic [BIAS_WIDTH-1:0]   aobias_q;

    // Track the host settings while reset is held, freeze on release
    always_ff @(posedge clk) begin
        if (reset) begin
            vsw_q    <= vsw_value;
            hsw_q    <= hsw_value;
            vref_q   <= vref_value;
            config_q <= config_value;
            nbias_q  <= nbias_value;
            aobias_q <= aobias_value;
        end
    end

    // Select by chip register number
    always_comb begin
        case (setting_sel)
            COLSEL_IDX: setting_value = '0;
            ROWSEL_IDX: setting_value = '0;
            VSW_IDX:    setting_value = reg_value_t'(vsw_q);
            HSW_IDX:    setting_value = reg_value_t'(hsw_q);
            VREF_IDX:   setting_value = reg_value_t'(vref_q);
            CONFIG_IDX: setting_value = reg_value_t'(config_q);
            NBIAS_IDX:  setting_value = reg_value_t'(nbias_q);
            default:    setting_value = reg_value_t'(aobias_q);
        endcase
    end

endmodule

/* design/stonyman_top.sv */
`timescale 1ns/100ps

module stonyman_top
    import stonyman_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,

    // Host control
    input  logic                    frame_capture_start,
    output logic                    frame_capture_done,
    input  logic                    capture_pixel,
    output pixel_coord_t            pixel_row,
    output pixel_coord_t            pixel_col,

    // Settings, sampled during reset
    input  logic [SWITCH_WIDTH-1:0] vsw_value,
    input  logic [SWITCH_WIDTH-1:0] hsw_value,
    input  logic [BIAS_WIDTH-1:0]   vref_value,
    input  logic [BIAS_WIDTH-1:0]   config_value,
    input  logic [BIAS_WIDTH-1:0]   nbias_value,
    input  logic [BIAS_WIDTH-1:0]   aobias_value,

    // External ADC
    output logic                    adc_capture_start,
    input  logic                    adc_capture_done,

    // Imager pins
    output logic                    resp,
    output logic                    incp,
    output logic                    resv,
    output logic                    incv
);

    reg_index_t setting_sel;
    reg_value_t setting_value;
    logic       cmd_req;
    logic       cmd_is_value;
    logic       cmd_force_reset;
    reg_value_t cmd_target;
    logic       cmd_ack;

    stonyman_settings u_settings (
        .clk           (clk),
        .reset         (reset),
        .vsw_value     (vsw_value),
        .hsw_value     (hsw_value),
        .vref_value    (vref_value),
        .config_value  (config_value),
        .nbias_value   (nbias_value),
        .aobias_value  (aobias_value),
        .setting_sel   (setting_sel),
        .setting_value (setting_value)
    );

    stonyman_sequencer u_sequencer (
        .clk                 (clk),
        .reset               (reset),
        .frame_capture_start (frame_capture_start),
        .capture_pixel       (capture_pixel),
        .adc_capture_done    (adc_capture_done),
        .frame_capture_done  (frame_capture_done),
        .adc_capture_start   (adc_capture_start),
        .pixel_row           (pixel_row),
        .pixel_col           (pixel_col),
        .setting_sel         (setting_sel),
        .setting_value       (setting_value),
        .cmd_req             (cmd_req),
        .cmd_is_value        (cmd_is_value),
        .cmd_force_reset     (cmd_force_reset),
        .cmd_target          (cmd_target),
        .cmd_ack             (cmd_ack)
    );

    stonyman_pin_driver u_pin_driver (
        .clk             (clk),
        .reset           (reset),
        .cmd_req         (cmd_req),
        .cmd_is_value    (cmd_is_value),
        .cmd_force_reset (cmd_force_reset),
        .cmd_target      (cmd_target),
        .cmd_ack         (cmd_ack),
        .resp            (resp),
        .incp            (incp),
        .resv            (resv),
        .incv            (incv)
    );

endmodule

/* verif/stonyman_chk.sv */
`timescale 1ns/100ps

module stonyman_chk
    import stonyman_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic resp,
    input logic incp,
    input logic resv,
    input logic incv,
    input logic adc_capture_start,
    input logic cmd_req,
    input logic cmd_ack
);

    logic any_pulse;

    assign any_pulse = resp | incp | resv | incv;

    ////////////////////////////////////////
    // Pin rules
    ////////////////////////////////////////
    a_one_line: assert property (@(posedge clk) disable iff (reset)
        $onehot0({resp, incp, resv, incv}))
        else $error("more than one pulse line high");

    a_pulse_width: assert property (@(posedge clk) disable iff (reset)
        $rose(any_pulse) |-> any_pulse [* PULSE_HIGH_CYCLES] ##1 !any_pulse)
        else $error("pulse width wrong");

    a_adc_start: assert property (@(posedge clk) disable iff (reset)
        adc_capture_start |=> !adc_capture_start)
        else $error("adc_capture_start longer than one cycle");

    // Four-phase command handshake
    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        cmd_req && !cmd_ack |=> cmd_req)
        else $error("cmd_req dropped before cmd_ack");

    a_req_rise: assert property (@(posedge clk) disable iff (reset)
        cmd_ack |-> !$rose(cmd_req))
        else $error("cmd_req rose while cmd_ack high");

endmodule

bind stonyman_top stonyman_chk u_chk (
    .clk               (clk),
    .reset             (reset),
    .resp              (resp),
    .incp              (incp),
    .resv              (resv),
    .incv              (incv),
    .adc_capture_start (adc_capture_start),
    .cmd_req           (cmd_req),
    .cmd_ack           (cmd_ack)
);

/* verif/stonyman_tb.sv */
`timescale 1ns/100ps

module stonyman_tb
    import stonyman_pkg::*;
();

    localparam int FRAME_TIMEOUT = 1000000;
    localparam int INIT_TIMEOUT  = 10000;

    logic clk;
    logic reset;
    logic frame_capture_start;
    logic frame_capture_done;
    logic capture_pixel;
    logic full_mask;
    pixel_coord_t pixel_row;
    pixel_coord_t pixel_col;
    logic [SWITCH_WIDTH-1:0] vsw, hsw;
    logic [BIAS_WIDTH-1:0] vref, cfg, nbias, aobias;
    logic adc_capture_start;
    logic adc_capture_done;
    logic resp, incp, resv, incv;

    logic [31:0] rng;
    int errors, tests_run, tests_failed, errors_at_start;
    int capture_count, done_count, adc_overlaps;
    logic [13:0] exp_q [$];
    logic [13:0] first_capture;

    // Chip model state
    reg_index_t chip_ptr;
    reg_value_t chip_regs [NUM_REGS];
    logic [3:0] prev_lines;

    // ADC model state
    logic adc_pending;
    int adc_wait;

    stonyman_top DUT (
        .clk(clk), .reset(reset),
        .frame_capture_start(frame_capture_start), .frame_capture_done(frame_capture_done),
        .capture_pixel(capture_pixel), .pixel_row(pixel_row), .pixel_col(pixel_col),
        .vsw_value(vsw), .hsw_value(hsw), .vref_value(vref), .config_value(cfg),
        .nbias_value(nbias), .aobias_value(aobias),
        .adc_capture_start(adc_capture_start), .adc_capture_done(adc_capture_done),
        .resp(resp), .incp(incp), .resv(resv), .incv(incv)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = lcg(rng);
        return rng;
    endfunction

    function automatic logic mask_bit(input pixel_coord_t r, input pixel_coord_t c);
        logic [31:0] h;
        h = lcg(lcg({18'h0, r, c} ^ 32'h6a93));
        return h[20];
    endfunction

    assign capture_pixel = full_mask ? 1'b1 : mask_bit(pixel_row, pixel_col);

    // Reference list of captured pixels in raster order
    function automatic void build_expected(input logic full);
        exp_q.delete();
        for (int r = 0; r < ROW_RESOLUTION; r++) begin
            for (int c = 0; c < COL_RESOLUTION; c++) begin
                if (full || mask_bit(pixel_coord_t'(r), pixel_coord_t'(c))) begin
                    exp_q.push_back({pixel_coord_t'(r), pixel_coord_t'(c)});
                end
            end
        end
    endfunction

    task automatic compare_value(input string name, input reg_value_t got, input reg_value_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_coord(input string name, input pixel_coord_t got,
                                 input pixel_coord_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic test_begin();
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic test_end(input string name);
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout while waiting for %s", what);
        $display("*** FAILED ***");
        $finish;
    endtask

    ////////////////////////////////////////
    // Chip model acting on falling edges
    ////////////////////////////////////////
    always @(negedge clk) begin
        if (reset) begin
            chip_ptr = '0;
            for (int i = 0; i < NUM_REGS; i++) chip_regs[i] = 8'hxx;
        end else begin
            if (prev_lines[3] && !resp) chip_ptr = '0;
            if (prev_lines[2] && !incp) chip_ptr = chip_ptr + reg_index_t'(1);
            if (prev_lines[1] && !resv) chip_regs[chip_ptr] = '0;
            if (prev_lines[0] && !incv) chip_regs[chip_ptr] = chip_regs[chip_ptr] + 8'd1;
        end
        prev_lines = {resp, incp, resv, incv};
    end

    // ADC answers after 0 to 7 cycles
    always @(posedge clk) begin
        #1;
        if (adc_capture_done) begin
            adc_capture_done = 1'b0;
        end else if (adc_pending) begin
            if (adc_wait == 0) begin
                adc_capture_done = 1'b1;
                adc_pending = 1'b0;
            end else begin
                adc_wait--;
            end
        end
        if (!reset && adc_capture_start) begin
            if (adc_pending || adc_capture_done) adc_overlaps++;
            adc_pending = 1'b1;
            adc_wait = int'(next_rand() >> 16) % 8;
        end
    end

    // Capture and frame end compare
    always @(negedge clk) begin
        logic [13:0] e;
        if (!reset && adc_capture_start) begin
            if (capture_count == 0) first_capture = {pixel_row, pixel_col};
            if (exp_q.size() == 0) begin
                $display("Capture at row %0d col %0d not in the expected list",
                         pixel_row, pixel_col);
                errors++;
            end else begin
                e = exp_q.pop_front();
                compare_coord("pixel_row", pixel_row, e[13:7]);
                compare_coord("pixel_col", pixel_col, e[6:0]);
            end
            compare_value("chip rowsel", chip_regs[ROWSEL_IDX], reg_value_t'(pixel_row));
            compare_value("chip colsel", chip_regs[COLSEL_IDX], reg_value_t'(pixel_col));
            capture_count++;
        end
        if (!reset && frame_capture_done) begin
            done_count++;
            if (exp_q.size() != 0) begin
                $display("Frame done with %0d pixels still expected", exp_q.size());
                errors++;
            end
        end
    end

    task automatic run_frame(input logic full, input string name);
        int n;
        build_expected(full);
        capture_count = 0;
        done_count = 0;
        @(posedge clk);
        #1;
        full_mask = full;
        frame_capture_start = 1'b1;
        @(posedge clk);
        #1 frame_capture_start = 1'b0;
        n = 0;
        while (done_count == 0) begin
            @(negedge clk);
            n++;
            if (n > FRAME_TIMEOUT) timeout_fail({"frame_capture_done in ", name});
        end
        repeat (20) @(negedge clk);
        compare_value("frame_capture_done count", reg_value_t'(done_count), 8'd1);
        if (exp_q.size() != 0) begin
            $display("%0d expected captures never happened", exp_q.size());
            errors++;
        end
    endtask

    initial begin
        int n;
        clk = 1'b0;
        reset = 1'b1;
        frame_capture_start = 1'b0;
        full_mask = 1'b1;
        adc_capture_done = 1'b0;
        adc_pending = 1'b0;
        adc_wait = 0;
        prev_lines = '0;
        rng = 32'h6a93;
        vsw = SWITCH_WIDTH'(next_rand() >> 16);
        hsw = SWITCH_WIDTH'(next_rand() >> 16);
        vref = BIAS_WIDTH'(next_rand() >> 16);
        cfg = BIAS_WIDTH'(next_rand() >> 16);
        nbias = BIAS_WIDTH'(next_rand() >> 16);
        aobias = BIAS_WIDTH'(next_rand() >> 16);

        // Reset state during reset and on the first cycle after
        test_begin();
        repeat (4) begin
            @(negedge clk);
            compare_value("pins", reg_value_t'({adc_capture_start, frame_capture_done,
                          resp, incp, resv, incv}), 8'd0);
            compare_coord("pixel_row", pixel_row, '0);
            compare_coord("pixel_col", pixel_col, '0);
        end
        @(posedge clk);
        #1 reset = 1'b0;
        @(posedge clk);
        @(negedge clk);
        compare_value("pins", reg_value_t'({adc_capture_start, frame_capture_done,
                      resp, incp, resv, incv}), 8'd0);
        compare_coord("pixel_row", pixel_row, '0);
        compare_coord("pixel_col", pixel_col, '0);
        test_end("reset state");

        // Init leaves the chip programmed
        test_begin();
        n = 0;
        while (DUT.u_sequencer.state != SEQ_IDLE) begin
            @(negedge clk);
            n++;
            if (n > INIT_TIMEOUT) timeout_fail("end of init");
        end
        @(negedge clk);
        compare_value("chip colsel", chip_regs[COLSEL_IDX], 8'd0);
        compare_value("chip rowsel", chip_regs[ROWSEL_IDX], 8'd0);
        compare_value("chip vsw", chip_regs[VSW_IDX], vsw);
        compare_value("chip hsw", chip_regs[HSW_IDX], hsw);
        compare_value("chip vref", chip_regs[VREF_IDX], {2'b00, vref});
        compare_value("chip config", chip_regs[CONFIG_IDX], {2'b00, cfg});
        compare_value("chip nbias", chip_regs[NBIAS_IDX], {2'b00, nbias});
        compare_value("chip aobias", chip_regs[AOBIAS_IDX], {2'b00, aobias});
        test_end("init result");

        test_begin();
        run_frame(1'b1, "full mask");
        if (capture_count != ROW_RESOLUTION * COL_RESOLUTION) begin
            $display("Full frame captured %0d pixels instead of %0d", capture_count,
                     ROW_RESOLUTION * COL_RESOLUTION);
            errors++;
        end
        test_end("full-mask frame");

        test_begin();
        run_frame(1'b0, "sparse mask");
        if (adc_overlaps != 0) begin
            $display("ADC started %0d times while still busy", adc_overlaps);
            errors++;
        end
        test_end("sparse mask with ADC delays");

        // Another frame restarts at the origin
        test_begin();
        run_frame(1'b1, "frame restart");
        compare_coord("first row", first_capture[13:7], '0);
        compare_coord("first col", first_capture[6:0], '0);
        test_end("frame end");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
